// ==== hw/rv_exec_pkg.sv ====
package rv_exec_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int STAT_WIDTH = 6;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [31:0]           instr_t;
    typedef logic [4:0]            alu_type_t;
    typedef logic [1:0]            kind_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            wb_idx_t;

    // operation codes follow the numbering of the ALU operation table
    localparam alu_type_t ALU_X    = 5'd0;
    localparam alu_type_t ALU_ADD  = 5'd1;
    localparam alu_type_t ALU_JALR = 5'd2;
    localparam alu_type_t ALU_BEQ  = 5'd3;
    localparam alu_type_t ALU_BNE  = 5'd4;
    localparam alu_type_t ALU_BLT  = 5'd5;
    localparam alu_type_t ALU_BGE  = 5'd6;
    localparam alu_type_t ALU_BLTU = 5'd7;
    localparam alu_type_t ALU_BGEU = 5'd8;
    localparam alu_type_t ALU_SLT  = 5'd9;
    localparam alu_type_t ALU_SLTU = 5'd10;
    localparam alu_type_t ALU_XOR  = 5'd11;
    localparam alu_type_t ALU_OR   = 5'd12;
    localparam alu_type_t ALU_AND  = 5'd13;
    localparam alu_type_t ALU_SLL  = 5'd14;
    localparam alu_type_t ALU_SRL  = 5'd15;
    localparam alu_type_t ALU_SRA  = 5'd16;
    localparam alu_type_t ALU_SUB  = 5'd17;

    localparam kind_t KIND_ARITH   = 2'd0;
    localparam kind_t KIND_BRANCH  = 2'd1;
    localparam kind_t KIND_JALR    = 2'd2;
    localparam kind_t KIND_ILLEGAL = 2'd3;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // word index taken from address bits 4..2
    localparam wb_idx_t REG_RS1    = 3'd0;
    localparam wb_idx_t REG_RS2    = 3'd1;
    localparam wb_idx_t REG_INSTR  = 3'd2;
    localparam wb_idx_t REG_RESULT = 3'd3;
    localparam wb_idx_t REG_STATUS = 3'd4;

    localparam int STAT_DONE    = 0;
    localparam int STAT_ZERO    = 1;
    localparam int STAT_OVER    = 2;
    localparam int STAT_NEGA    = 3;
    localparam int STAT_TAKEN   = 4;
    localparam int STAT_ILLEGAL = 5;

endpackage

// ==== hw/exec_if.sv ====
`timescale 1ns/1ps

// decoded operation on its way into the ALU
interface alu_req_if;
    logic                   valid;
    rv_exec_pkg::alu_type_t alu_type;
    rv_exec_pkg::data_t     op_a;
    rv_exec_pkg::data_t     op_b;
    rv_exec_pkg::kind_t     kind;
    rv_exec_pkg::data_t     rs1;

    modport drv (output valid, alu_type, op_a, op_b, kind, rs1);
    modport rcv (input  valid, alu_type, op_a, op_b, kind, rs1);
endinterface

// registered ALU result with its flags
interface alu_rsp_if;
    logic                   valid;
    rv_exec_pkg::alu_type_t alu_type;
    rv_exec_pkg::kind_t     kind;
    rv_exec_pkg::data_t     res;
    logic                   zero;
    logic                   over;
    logic                   nega;

    modport drv (output valid, alu_type, kind, res, zero, over, nega);
    modport rcv (input  valid, alu_type, kind, res, zero, over, nega);
endinterface

// ==== hw/wb_exec_regs.sv ====
`timescale 1ns/1ps

module wb_exec_regs (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  logic [31:0]         i_wb_adr,
    input  logic [31:0]         i_wb_dat,
    input  logic [3:0]          i_wb_sel,
    output logic [31:0]         o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_issue,
    output rv_exec_pkg::instr_t o_instr,
    output rv_exec_pkg::data_t  o_rs1,
    output rv_exec_pkg::data_t  o_rs2,
    input  logic                i_done,
    input  rv_exec_pkg::data_t  i_rd,
    input  logic                i_zero,
    input  logic                i_over,
    input  logic                i_nega,
    input  logic                i_taken,
    input  logic                i_illegal
);

    rv_exec_pkg::wb_idx_t                   w_idx;
    logic                                   w_mapped;
    logic                                   w_access;
    logic                                   w_write;
    logic [rv_exec_pkg::STAT_WIDTH-1:0]     r_status;
    rv_exec_pkg::data_t                     r_result;

    assign w_idx    = i_wb_adr[4:2];
    // anything above the five word slots reads as zero instead of aliasing
    assign w_mapped = (i_wb_adr[31:5] == '0);
    // ack is low for at least one cycle between accesses
    assign w_access = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign w_write  = w_access && i_wb_we && w_mapped && (i_wb_sel == 4'hf);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_ack <= 1'b0;
            o_issue  <= 1'b0;
            o_wb_dat <= '0;
            r_status <= '0;
            r_result <= '0;
        end else begin
            o_wb_ack <= w_access;
            o_issue  <= w_write && (w_idx == rv_exec_pkg::REG_INSTR);

            if (w_access && !i_wb_we) begin
                if (!w_mapped) begin
                    o_wb_dat <= '0;
                end else begin
                    case (w_idx)
                        rv_exec_pkg::REG_RS1:    o_wb_dat <= o_rs1;
                        rv_exec_pkg::REG_RS2:    o_wb_dat <= o_rs2;
                        rv_exec_pkg::REG_INSTR:  o_wb_dat <= o_instr;
                        rv_exec_pkg::REG_RESULT: o_wb_dat <= r_result;
                        rv_exec_pkg::REG_STATUS: o_wb_dat <= rv_exec_pkg::data_t'(r_status);
                        default:                 o_wb_dat <= '0;
                    endcase
                end
            end

            // a finishing instruction wins over a new INSTR write in the same cycle
            if (i_done) begin
                r_result                           <= i_rd;
                r_status[rv_exec_pkg::STAT_DONE]    <= 1'b1;
                r_status[rv_exec_pkg::STAT_ZERO]    <= i_zero;
                r_status[rv_exec_pkg::STAT_OVER]    <= i_over;
                r_status[rv_exec_pkg::STAT_NEGA]    <= i_nega;
                r_status[rv_exec_pkg::STAT_TAKEN]   <= i_taken;
                r_status[rv_exec_pkg::STAT_ILLEGAL] <= i_illegal;
            end else if (w_write && (w_idx == rv_exec_pkg::REG_INSTR)) begin
                r_status[rv_exec_pkg::STAT_DONE] <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_write) begin
            case (w_idx)
                rv_exec_pkg::REG_RS1:   o_rs1   <= i_wb_dat;
                rv_exec_pkg::REG_RS2:   o_rs2   <= i_wb_dat;
                rv_exec_pkg::REG_INSTR: o_instr <= i_wb_dat;
                default: ;
            endcase
        end
    end

    // the host holds stb until ack, so ack always finds stb and lasts a single cycle
    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb_ack |-> i_wb_stb ##1 !o_wb_ack);

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_issue,
    input  rv_exec_pkg::instr_t i_instr,
    input  rv_exec_pkg::data_t  i_rs1,
    input  rv_exec_pkg::data_t  i_rs2,
    alu_req_if.drv              o_req
);

    rv_exec_pkg::opcode_t   w_opcode;
    logic [2:0]             w_funct3;
    logic                   w_f7_zero;
    logic                   w_f7_alt;
    logic                   w_shift;
    rv_exec_pkg::data_t     w_imm;
    rv_exec_pkg::data_t     w_shamt;
    rv_exec_pkg::alu_type_t w_type;
    rv_exec_pkg::kind_t     w_kind;
    rv_exec_pkg::data_t     w_op_b;

    // shared funct3 table of OP and OP-IMM, alt selects SUB and SRA
    function automatic rv_exec_pkg::alu_type_t arith_type(input logic [2:0] funct3,
                                                          input logic       alt);
        rv_exec_pkg::alu_type_t t;
        case (funct3)
            3'd0:    t = alt ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
            3'd1:    t = rv_exec_pkg::ALU_SLL;
            3'd2:    t = rv_exec_pkg::ALU_SLT;
            3'd3:    t = rv_exec_pkg::ALU_SLTU;
            3'd4:    t = rv_exec_pkg::ALU_XOR;
            3'd5:    t = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
            3'd6:    t = rv_exec_pkg::ALU_OR;
            default: t = rv_exec_pkg::ALU_AND;
        endcase
        return t;
    endfunction

    assign w_opcode  = i_instr[6:0];
    assign w_funct3  = i_instr[14:12];
    assign w_f7_zero = (i_instr[31:25] == 7'b0000000);
    assign w_f7_alt  = (i_instr[31:25] == 7'b0100000);
    assign w_shift   = (w_funct3[1:0] == 2'b01);
    assign w_imm     = {{20{i_instr[31]}}, i_instr[31:20]};
    assign w_shamt   = {27'd0, i_instr[24:20]};

    always_comb begin
        w_type = rv_exec_pkg::ALU_X;
        w_kind = rv_exec_pkg::KIND_ILLEGAL;
        w_op_b = i_rs2;
        case (w_opcode)
            rv_exec_pkg::OPC_OP: begin
                if (w_f7_zero || (w_f7_alt && (w_funct3 == 3'd0 || w_funct3 == 3'd5))) begin
                    w_type = arith_type(w_funct3, w_f7_alt);
                    w_kind = rv_exec_pkg::KIND_ARITH;
                end
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                w_op_b = w_shift ? w_shamt : w_imm;
                // only the shift immediates carry a funct7 field
                if (!w_shift || w_f7_zero || (w_f7_alt && w_funct3 == 3'd5)) begin
                    w_type = arith_type(w_funct3, w_shift && w_f7_alt);
                    w_kind = rv_exec_pkg::KIND_ARITH;
                end
            end
            rv_exec_pkg::OPC_BRANCH: begin
                w_kind = rv_exec_pkg::KIND_BRANCH;
                case (w_funct3)
                    3'd0:    w_type = rv_exec_pkg::ALU_BEQ;
                    3'd1:    w_type = rv_exec_pkg::ALU_BNE;
                    3'd4:    w_type = rv_exec_pkg::ALU_BLT;
                    3'd5:    w_type = rv_exec_pkg::ALU_BGE;
                    3'd6:    w_type = rv_exec_pkg::ALU_BLTU;
                    3'd7:    w_type = rv_exec_pkg::ALU_BGEU;
                    default: w_kind = rv_exec_pkg::KIND_ILLEGAL;
                endcase
            end
            rv_exec_pkg::OPC_JALR: begin
                w_op_b = w_imm;
                if (w_funct3 == 3'd0) begin
                    w_type = rv_exec_pkg::ALU_JALR;
                    w_kind = rv_exec_pkg::KIND_JALR;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_req.valid <= 1'b0;
        end else begin
            o_req.valid <= i_issue;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue) begin
            o_req.alu_type <= w_type;
            o_req.kind     <= w_kind;
            o_req.op_a     <= i_rs1;
            o_req.op_b     <= w_op_b;
            o_req.rs1      <= i_rs1;
        end
    end

    // an illegal instruction must reach the ALU as a no-op
    a_illegal_is_x: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_req.valid && (o_req.kind == rv_exec_pkg::KIND_ILLEGAL)
            |-> o_req.alu_type == rv_exec_pkg::ALU_X);

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic   i_clk,
    input  logic   i_arst_n,
    alu_req_if.rcv i_req,
    alu_rsp_if.drv o_rsp
);

    rv_exec_pkg::data_t w_res;
    rv_exec_pkg::data_t w_target;
    logic [4:0]         w_shamt;
    logic               w_lt;
    logic               w_ltu;
    logic               w_a_sign;
    logic               w_b_sign;
    logic               w_r_sign;
    logic               w_over;

    assign w_shamt  = i_req.op_b[4:0];
    assign w_lt     = $signed(i_req.op_a) < $signed(i_req.op_b);
    assign w_ltu    = i_req.op_a < i_req.op_b;
    // jump target keeps bit 0 clear as RV32I requires
    assign w_target = (i_req.rs1 + i_req.op_b) & ~rv_exec_pkg::data_t'(1);

    always_comb begin
        case (i_req.alu_type)
            rv_exec_pkg::ALU_ADD:  w_res = i_req.op_a + i_req.op_b;
            rv_exec_pkg::ALU_SUB:  w_res = i_req.op_a - i_req.op_b;
            rv_exec_pkg::ALU_XOR:  w_res = i_req.op_a ^ i_req.op_b;
            rv_exec_pkg::ALU_OR:   w_res = i_req.op_a | i_req.op_b;
            rv_exec_pkg::ALU_AND:  w_res = i_req.op_a & i_req.op_b;
            rv_exec_pkg::ALU_SLL:  w_res = i_req.op_a << w_shamt;
            rv_exec_pkg::ALU_SRL:  w_res = i_req.op_a >> w_shamt;
            rv_exec_pkg::ALU_SRA:  w_res = rv_exec_pkg::data_t'($signed(i_req.op_a) >>> w_shamt);
            rv_exec_pkg::ALU_SLT:  w_res = {rv_exec_pkg::DATA_WIDTH{w_lt}};
            rv_exec_pkg::ALU_SLTU: w_res = {rv_exec_pkg::DATA_WIDTH{w_ltu}};
            rv_exec_pkg::ALU_BEQ:  w_res = {rv_exec_pkg::DATA_WIDTH{i_req.op_a == i_req.op_b}};
            rv_exec_pkg::ALU_BNE:  w_res = {rv_exec_pkg::DATA_WIDTH{i_req.op_a != i_req.op_b}};
            rv_exec_pkg::ALU_BLT:  w_res = {rv_exec_pkg::DATA_WIDTH{w_lt}};
            rv_exec_pkg::ALU_BGE:  w_res = {rv_exec_pkg::DATA_WIDTH{!w_lt}};
            rv_exec_pkg::ALU_BLTU: w_res = {rv_exec_pkg::DATA_WIDTH{w_ltu}};
            rv_exec_pkg::ALU_BGEU: w_res = {rv_exec_pkg::DATA_WIDTH{!w_ltu}};
            rv_exec_pkg::ALU_JALR: w_res = w_target;
            default:               w_res = '0;
        endcase
    end

    assign w_a_sign = i_req.op_a[rv_exec_pkg::DATA_WIDTH-1];
    assign w_b_sign = i_req.op_b[rv_exec_pkg::DATA_WIDTH-1];
    assign w_r_sign = w_res[rv_exec_pkg::DATA_WIDTH-1];

    // add overflows on equal operand signs, sub on different ones, when the result flips sign
    assign w_over = ((i_req.alu_type == rv_exec_pkg::ALU_ADD) &&
                     (w_a_sign == w_b_sign) && (w_r_sign != w_a_sign)) ||
                    ((i_req.alu_type == rv_exec_pkg::ALU_SUB) &&
                     (w_a_sign != w_b_sign) && (w_r_sign != w_a_sign));

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rsp.valid <= 1'b0;
        end else begin
            o_rsp.valid <= i_req.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.valid) begin
            o_rsp.alu_type <= i_req.alu_type;
            o_rsp.kind     <= i_req.kind;
            o_rsp.res      <= w_res;
            o_rsp.zero     <= (w_res == '0);
            o_rsp.over     <= w_over;
            o_rsp.nega     <= w_r_sign;
        end
    end

    // operands written over the bus must reach the result fully defined
    a_res_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_rsp.valid |-> !$isunknown(o_rsp.res));

endmodule

// ==== hw/rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
    input  logic               i_clk,
    input  logic               i_arst_n,
    alu_rsp_if.rcv             i_rsp,
    output logic               o_done,
    output rv_exec_pkg::data_t o_rd,
    output logic               o_zero,
    output logic               o_over,
    output logic               o_nega,
    output logic               o_taken,
    output logic               o_illegal
);

    rv_exec_pkg::data_t w_rd;
    logic               w_taken;

    always_comb begin
        w_rd    = '0;
        w_taken = 1'b0;
        case (i_rsp.kind)
            rv_exec_pkg::KIND_ARITH: begin
                // set-less-than writes 1 or 0 to rd, not the all-ones compare mask
                if (i_rsp.alu_type == rv_exec_pkg::ALU_SLT ||
                    i_rsp.alu_type == rv_exec_pkg::ALU_SLTU) begin
                    w_rd = rv_exec_pkg::data_t'(i_rsp.res[0]);
                end else begin
                    w_rd = i_rsp.res;
                end
            end
            rv_exec_pkg::KIND_BRANCH: w_taken = i_rsp.res[0];
            rv_exec_pkg::KIND_JALR: begin
                w_rd    = i_rsp.res;
                w_taken = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_done <= 1'b0;
        end else begin
            o_done <= i_rsp.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rsp.valid) begin
            o_rd      <= w_rd;
            o_zero    <= i_rsp.zero;
            o_over    <= i_rsp.over;
            o_nega    <= i_rsp.nega;
            o_taken   <= w_taken;
            o_illegal <= (i_rsp.kind == rv_exec_pkg::KIND_ILLEGAL);
        end
    end

endmodule

// ==== hw/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [31:0] i_wb_adr,
    input  logic [31:0] i_wb_dat,
    input  logic [3:0]  i_wb_sel,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack
);

    logic                issue;
    rv_exec_pkg::instr_t instr;
    rv_exec_pkg::data_t  rs1;
    rv_exec_pkg::data_t  rs2;
    logic                done;
    rv_exec_pkg::data_t  rd;
    logic                zero;
    logic                over;
    logic                nega;
    logic                taken;
    logic                illegal;

    alu_req_if req_if ();
    alu_rsp_if rsp_if ();

    wb_exec_regs u_regs (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .i_wb_sel  (i_wb_sel),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_issue   (issue),
        .o_instr   (instr),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .i_done    (done),
        .i_rd      (rd),
        .i_zero    (zero),
        .i_over    (over),
        .i_nega    (nega),
        .i_taken   (taken),
        .i_illegal (illegal)
    );

    rv_decode u_decode (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_issue  (issue),
        .i_instr  (instr),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .o_req    (req_if.drv)
    );

    alu u_alu (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (req_if.rcv),
        .o_rsp    (rsp_if.drv)
    );

    rv_result u_result (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rsp     (rsp_if.rcv),
        .o_done    (done),
        .o_rd      (rd),
        .o_zero    (zero),
        .o_over    (over),
        .o_nega    (nega),
        .o_taken   (taken),
        .o_illegal (illegal)
    );

endmodule

// ==== tests/exec_checker.sv ====
`timescale 1ns/1ps

module exec_checker (
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [31:0] i_wb_adr,
    input  logic [31:0] i_wb_dat,
    input  logic [31:0] i_wb_rdat,
    input  logic        i_wb_ack,
    output int          o_errors,
    output int          o_checks
);

    logic [31:0] rs1_q = '0;
    logic [31:0] rs2_q = '0;
    logic [31:0] exp_result = '0;
    logic [31:0] exp_status = '0;
    logic        issued = 1'b0;

    // expected {STATUS, RESULT} of one instruction on the given source operands
    function automatic logic [63:0] exec_ref(input logic [31:0] ins, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] opb;
        logic [32:0] wide;
        logic [31:0] res;
        logic [31:0] rd;
        logic [31:0] status;
        logic        legal;
        logic        cond;
        logic        over;
        logic        taken;
        logic        shift;
        logic        alt;
        f3    = ins[14:12];
        imm   = {{20{ins[31]}}, ins[31:20]};
        shift = (f3 == 3'd1) || (f3 == 3'd5);
        alt   = (ins[31:25] == 7'h20);
        legal = 1'b0;
        cond  = 1'b0;
        over  = 1'b0;
        taken = 1'b0;
        res   = '0;
        rd    = '0;
        opb   = b;
        if (ins[6:0] == rv_exec_pkg::OPC_OP) begin
            legal = (ins[31:25] == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
        end else if (ins[6:0] == rv_exec_pkg::OPC_OP_IMM) begin
            opb   = shift ? {27'd0, ins[24:20]} : imm;
            legal = !shift || (ins[31:25] == 7'h00) || (alt && f3 == 3'd5);
            alt   = alt && shift;
        end
        if (legal) begin
            case (f3)
                3'd0: begin
                    wide = alt ? {a[31], a} - {opb[31], opb} : {a[31], a} + {opb[31], opb};
                    res  = wide[31:0];
                    over = (wide[32] != wide[31]);
                end
                3'd1: res = a << opb[4:0];
                3'd2: cond = ($signed(a) < $signed(opb));
                3'd3: cond = (a < opb);
                3'd4: res = a ^ opb;
                3'd5: res = (a >> opb[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> opb[4:0]) : '0);
                3'd6: res = a | opb;
                default: res = a & opb;
            endcase
            // set-less-than writes 1 or 0 while the ALU flags see the all-ones mask
            if (f3 == 3'd2 || f3 == 3'd3) begin
                res = {32{cond}};
                rd  = {31'd0, cond};
            end else begin
                rd = res;
            end
        end
        if (ins[6:0] == rv_exec_pkg::OPC_BRANCH) begin
            legal = (f3 != 3'd2) && (f3 != 3'd3);
            case (f3)
                3'd0:    cond = (a == b);
                3'd1:    cond = (a != b);
                3'd4:    cond = ($signed(a) < $signed(b));
                3'd5:    cond = ($signed(a) >= $signed(b));
                3'd6:    cond = (a < b);
                default: cond = (a >= b);
            endcase
            taken = cond && legal;
            res   = {32{taken}};
        end
        if (ins[6:0] == rv_exec_pkg::OPC_JALR && f3 == 3'd0) begin
            legal = 1'b1;
            res   = (a + imm) & 32'hffff_fffe;
            rd    = res;
            taken = 1'b1;
        end
        status = '0;
        status[rv_exec_pkg::STAT_DONE]    = 1'b1;
        status[rv_exec_pkg::STAT_ZERO]    = (res == '0);
        status[rv_exec_pkg::STAT_OVER]    = over;
        status[rv_exec_pkg::STAT_NEGA]    = res[31];
        status[rv_exec_pkg::STAT_TAKEN]   = taken;
        status[rv_exec_pkg::STAT_ILLEGAL] = !legal;
        return {status, rd};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        o_checks = o_checks + 1;
        if (act !== exp) begin
            o_errors = o_errors + 1;
            $display("ERROR at time %0t: %s read expected %h, got %h", $time, name, exp, act);
        end
    endtask

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    // every access acks in exactly one cycle, so each one is seen at one falling edge
    always @(negedge i_clk) begin : bus_monitor
        logic [2:0] idx;
        logic       mapped;
        idx    = i_wb_adr[4:2];
        mapped = (i_wb_adr[31:5] == '0) && (idx <= rv_exec_pkg::REG_STATUS);
        if (i_arst_n && i_wb_cyc && i_wb_stb && i_wb_ack) begin
            if (i_wb_we) begin
                if (mapped && idx == rv_exec_pkg::REG_RS1) begin
                    rs1_q = i_wb_dat;
                end else if (mapped && idx == rv_exec_pkg::REG_RS2) begin
                    rs2_q = i_wb_dat;
                end else if (mapped && idx == rv_exec_pkg::REG_INSTR) begin
                    {exp_status, exp_result} = exec_ref(i_wb_dat, rs1_q, rs2_q);
                    issued = 1'b1;
                end
            end else if (!mapped) begin
                compare_word("unmapped", '0, i_wb_rdat);
            end else if (idx == rv_exec_pkg::REG_RESULT) begin
                compare_word("RESULT", exp_result, i_wb_rdat);
            end else if (idx == rv_exec_pkg::REG_STATUS) begin
                if (!issued || i_wb_rdat[rv_exec_pkg::STAT_DONE]) begin
                    compare_word("STATUS", exp_status, i_wb_rdat);
                end
            end
        end
    end

endmodule

// ==== tests/tb_rv_exec.sv ====
`timescale 1ns/1ps

module tb_rv_exec;

    localparam int CYCLE_LIMIT = 10000;
    // funct3 of ADD SUB XOR OR AND SLL SRL SRA SLT SLTU with the first entry in the lowest bits
    localparam logic [29:0] ARITH_F3  = {3'd3, 3'd2, 3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4,
                                         3'd0, 3'd0};
    localparam logic [9:0]  ARITH_ALT = 10'b0010000010;
    localparam logic [17:0] BRANCH_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        wb_cyc = 1'b0;
    logic        wb_stb = 1'b0;
    logic        wb_we = 1'b0;
    logic [31:0] wb_adr = '0;
    logic [31:0] wb_dat = '0;
    logic [3:0]  wb_sel = 4'hf;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic [31:0] rng_state = 32'hb084;
    int          cycle_count = 0;
    int          error_count;
    int          check_count;

    always #4 clk = ~clk;

    rv_exec_top u_dut (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat),
        .i_wb_sel (wb_sel),
        .o_wb_dat (wb_rdat),
        .o_wb_ack (wb_ack)
    );

    exec_checker u_check (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_adr  (wb_adr),
        .i_wb_dat  (wb_dat),
        .i_wb_rdat (wb_rdat),
        .i_wb_ack  (wb_ack),
        .o_errors  (error_count),
        .o_checks  (check_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [2:0] idx);
        return {27'd0, idx, 2'b00};
    endfunction

    // register-register form with rs1=x1, rs2=x2, rd=x3
    function automatic logic [31:0] reg_instr(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, rv_exec_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] imm_instr(input logic [11:0] imm, input logic [2:0] f3,
                                              input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    // called on a falling edge, returns on a falling edge with the bus idle
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = wdata;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_rdat;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdata);
        bus_cycle(1'b0, adr, '0, rdata);
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic [31:0] ins);
        logic [31:0] data;
        wb_write(reg_addr(rv_exec_pkg::REG_RS1), a);
        wb_write(reg_addr(rv_exec_pkg::REG_RS2), b);
        wb_write(reg_addr(rv_exec_pkg::REG_INSTR), ins);
        data = '0;
        while (!data[rv_exec_pkg::STAT_DONE]) begin
            wb_read(reg_addr(rv_exec_pkg::REG_STATUS), data);
        end
        wb_read(reg_addr(rv_exec_pkg::REG_RESULT), data);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int          t;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ins;
        logic [31:0] data;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        wb_read(reg_addr(rv_exec_pkg::REG_STATUS), data);
        wb_read(reg_addr(rv_exec_pkg::REG_RESULT), data);
        wb_read(32'h0000_0014, data);
        wb_read(32'h0000_001c, data);
        wb_read(32'h0000_0100, data);

        for (t = 0; t < 10; t++) begin
            f3  = ARITH_F3[t*3 +: 3];
            alt = ARITH_ALT[t];
            for (n = 0; n < 8; n++) begin
                a = rand32();
                b = rand32();
                run_op(a, b, reg_instr(alt ? 7'h20 : 7'h00, f3));
                // there is no SUB immediate
                if (t != 1) begin
                    imm = (f3 == 3'd1 || f3 == 3'd5) ? {alt ? 7'h20 : 7'h00, b[4:0]} : b[11:0];
                    run_op(a, rand32(), imm_instr(imm, f3, rv_exec_pkg::OPC_OP_IMM));
                end
            end
        end

        for (n = 0; n < 2; n++) begin
            a = rand32() | 32'h8000_0000;
            b = (n == 0) ? 32'd0 : 32'd31;
            run_op(a, b, reg_instr(7'h00, 3'd1));
            run_op(a, b, reg_instr(7'h00, 3'd5));
            run_op(a, b, reg_instr(7'h20, 3'd5));
            run_op(a, b, imm_instr({7'h20, b[4:0]}, 3'd5, rv_exec_pkg::OPC_OP_IMM));
        end

        for (t = 0; t < 6; t++) begin
            for (n = 0; n < 9; n++) begin
                a = rand32();
                b = (n == 8) ? a : rand32();
                ins = rand32();
                run_op(a, b, imm_instr(ins[11:0], BRANCH_F3[t*3 +: 3], rv_exec_pkg::OPC_BRANCH));
            end
        end

        for (n = 0; n < 10; n++) begin
            a = rand32();
            b = rand32();
            ins = rand32();
            run_op(a, b, imm_instr(ins[11:0], 3'd0, rv_exec_pkg::OPC_JALR));
        end

        run_op(32'h7fff_ffff, 32'd1, reg_instr(7'h00, 3'd0));
        run_op(32'h7fff_ffff, 32'd0, imm_instr(12'h001, 3'd0, rv_exec_pkg::OPC_OP_IMM));
        run_op(32'h8000_0000, 32'd1, reg_instr(7'h20, 3'd0));
        run_op(32'h8000_0000, 32'hffff_ffff, reg_instr(7'h00, 3'd0));
        run_op(32'h7fff_ffff, 32'hffff_ffff, reg_instr(7'h20, 3'd0));
        run_op(32'd5, 32'hffff_fffb, reg_instr(7'h00, 3'd0));
        run_op(32'h1234_5678, 32'h1234_5678, reg_instr(7'h20, 3'd0));

        a = rand32();
        b = rand32();
        run_op(a, b, reg_instr(7'h01, 3'd0));
        run_op(a, b, reg_instr(7'h20, 3'd4));
        run_op(a, b, imm_instr({7'h20, 5'd3}, 3'd1, rv_exec_pkg::OPC_OP_IMM));
        run_op(a, b, imm_instr(12'h123, 3'd2, rv_exec_pkg::OPC_BRANCH));
        run_op(a, b, imm_instr(12'h123, 3'd3, rv_exec_pkg::OPC_BRANCH));
        run_op(a, b, imm_instr(12'h010, 3'd1, rv_exec_pkg::OPC_JALR));
        for (n = 0; n < 8; n++) begin
            ins = rand32();
            while (ins[6:0] == rv_exec_pkg::OPC_OP || ins[6:0] == rv_exec_pkg::OPC_OP_IMM ||
                   ins[6:0] == rv_exec_pkg::OPC_BRANCH || ins[6:0] == rv_exec_pkg::OPC_JALR) begin
                ins = rand32();
            end
            run_op(rand32(), b, ins);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/rv_exec_pkg.sv
hw/exec_if.sv
hw/wb_exec_regs.sv
hw/rv_decode.sv
hw/alu.sv
hw/rv_result.sv
hw/rv_exec_top.sv
tests/exec_checker.sv
tests/tb_rv_exec.sv
